/* common/mil1553_pkg.sv */
// MIL-STD-1553 receiver constants
// Clock and bus timing, window tolerance and word format

`default_nettype none

package mil1553_pkg;

    // ------------------------------------------------------------
    // Clock and bus rate
    // ------------------------------------------------------------
    localparam int unsigned CLK_FREQ_HZ = 250_000_000;  // 4 ns system clock
    localparam int unsigned BIT_RATE_HZ = 1_000_000;    // 1 Mbps bus

    localparam int unsigned TIMER_W = 10;  // Interval, phase and quiet timers

    // ------------------------------------------------------------
    // Chip timing in clock cycles
    // ------------------------------------------------------------
    // Two chips per Manchester bit
    localparam logic [TIMER_W-1:0] CYCLES_PER_CHIP  =
        TIMER_W'(CLK_FREQ_HZ / (2 * BIT_RATE_HZ));
    localparam logic [TIMER_W-1:0] CYCLES_HALF_CHIP = CYCLES_PER_CHIP / 2;  // Chip centre
    localparam logic [TIMER_W-1:0] CYCLES_TOL       = 10'd25;   // 100 ns early or late

    // Longest legal edge interval is four chips, data sync followed by a 1
    localparam logic [TIMER_W-1:0] CYCLES_TIMEOUT   =
        TIMER_W'(4 * CYCLES_PER_CHIP + CYCLES_TOL);
    localparam logic [TIMER_W-1:0] CYCLES_GAP       = 10'd250;  // Intermission after a word

    // ------------------------------------------------------------
    // Word format
    // ------------------------------------------------------------
    localparam int unsigned WORD_W     = 16;
    localparam int unsigned SYNC_CHIPS = 6;   // Three chips high, three low or inverse
    localparam int unsigned DATA_CHIPS = 34;  // 16 data bits and parity, two chips each

    localparam logic [SYNC_CHIPS-1:0] SYNC_CMD  = 6'b111000;  // Command or status
    localparam logic [SYNC_CHIPS-1:0] SYNC_DATA = ~SYNC_CMD;  // Data word

endpackage

`default_nettype wire

/* hdl/rx_line_front.sv */
// MIL-STD-1553 receive line front end
// Synchronizes both transceiver rails, finds bus start and data edges,
// runs the chip phase timer and checks every edge interval

`default_nettype none

module rx_line_front (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_rx_pos,       // Positive rail, high for a high chip
    input  logic i_rx_neg,       // Negative rail, high for a low chip
    output logic o_line,         // Synchronized positive rail
    output logic o_bus_start,    // Bus left idle
    output logic o_edge,         // Data edge while active
    output logic o_chip_center,  // Sample strobe
    output logic o_edge_bad,     // Edge outside all windows
    output logic o_timeout,      // No edge for too long
    output logic o_quiet         // Intermission reached
);

    logic [1:0] pos_sync;
    logic [1:0] neg_sync;
    logic       active;
    logic       active_q;
    logic       start_now;
    logic       edge_now;
    logic       restart;
    logic       in_window;
    logic [mil1553_pkg::TIMER_W-1:0] interval_cnt;
    logic [mil1553_pkg::TIMER_W-1:0] phase_cnt;
    logic [mil1553_pkg::TIMER_W-1:0] phase_nxt;
    logic [mil1553_pkg::TIMER_W-1:0] quiet_cnt;

    assign active    = pos_sync[1] | neg_sync[1];               // Idle bus has both rails low
    assign start_now = active & ~active_q;
    assign edge_now  = active & active_q & (pos_sync[1] != o_line);
    assign restart   = start_now | edge_now;                    // DPLL realigns here

    // Phase wraps once per chip unless an edge pulls it back to zero
    always_comb begin
        phase_nxt = phase_cnt + 1'b1;
        if (restart || phase_cnt == mil1553_pkg::CYCLES_PER_CHIP - 1'b1) begin
            phase_nxt = '0;
        end
    end

    // ------------------------------------------------------------
    // Window check, k chips +/- tolerance for k = 1..4
    // ------------------------------------------------------------
    always_comb begin
        logic [mil1553_pkg::TIMER_W-1:0] centre;
        in_window = 1'b0;
        centre    = mil1553_pkg::CYCLES_PER_CHIP;
        for (int k = 0; k < 4; k++) begin
            if (interval_cnt >= centre - mil1553_pkg::CYCLES_TOL &&
                interval_cnt <= centre + mil1553_pkg::CYCLES_TOL) begin
                in_window = 1'b1;
            end
            centre = centre + mil1553_pkg::CYCLES_PER_CHIP;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pos_sync      <= '0;
            neg_sync      <= '0;
            active_q      <= 1'b0;
            o_line        <= 1'b0;
            o_bus_start   <= 1'b0;
            o_edge        <= 1'b0;
            o_chip_center <= 1'b0;
            o_edge_bad    <= 1'b0;
            o_timeout     <= 1'b0;
            o_quiet       <= 1'b0;
            interval_cnt  <= '0;
            phase_cnt     <= '0;
            quiet_cnt     <= '0;
        end else begin
            pos_sync <= {pos_sync[0], i_rx_pos};  // Two flop stages per rail
            neg_sync <= {neg_sync[0], i_rx_neg};
            active_q <= active;
            o_line   <= pos_sync[1];

            o_bus_start   <= start_now;
            o_edge        <= edge_now;
            o_edge_bad    <= edge_now & ~in_window;
            o_chip_center <= (phase_nxt == mil1553_pkg::CYCLES_HALF_CHIP);
            o_timeout     <= ~restart & (interval_cnt >= mil1553_pkg::CYCLES_TIMEOUT);
            o_quiet       <= ~active & (quiet_cnt >= mil1553_pkg::CYCLES_GAP);
            phase_cnt     <= phase_nxt;

            // Interval since last edge or start, saturates
            if (restart) begin
                interval_cnt <= '0;
            end else if (interval_cnt != '1) begin
                interval_cnt <= interval_cnt + 1'b1;
            end

            if (active) begin
                quiet_cnt <= '0;
            end else if (quiet_cnt != '1) begin
                quiet_cnt <= quiet_cnt + 1'b1;  // Idle time
            end
        end
    end

    a_phase_range : assert property (@(posedge i_clk) disable iff (i_reset)
        phase_cnt <= mil1553_pkg::CYCLES_PER_CHIP)
        else $error("rx_line_front phase counter out of range: %0d", phase_cnt);

endmodule

`default_nettype wire

/* word_decoder/sync_detector.sv */
// MIL-STD-1553 sync detector
// Samples the six sync chips and tells command/status from data sync

`default_nettype none

module sync_detector (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_en,           // Held high for the sync field
    input  logic i_line,
    input  logic i_chip_center,
    output logic o_sync_done,    // Pulse, pattern matched
    output logic o_is_data,      // Data sync, valid with o_sync_done
    output logic o_sync_bad      // Pulse, neither pattern
);

    logic [2:0]                         chip_cnt;
    logic [mil1553_pkg::SYNC_CHIPS-1:0] chips;
    logic [mil1553_pkg::SYNC_CHIPS-1:0] pattern;
    logic                               match_cmd;
    logic                               match_data;

    // Pattern including the chip being sampled now, oldest chip in the MSB
    assign pattern    = {chips[mil1553_pkg::SYNC_CHIPS-2:0], i_line};
    assign match_cmd  = (pattern == mil1553_pkg::SYNC_CMD);
    assign match_data = (pattern == mil1553_pkg::SYNC_DATA);

    always_ff @(posedge i_clk) begin
        if (i_reset || !i_en) begin
            chip_cnt    <= '0;
            o_sync_done <= 1'b0;
            o_is_data   <= 1'b0;
            o_sync_bad  <= 1'b0;
        end else begin
            o_sync_done <= 1'b0;
            o_sync_bad  <= 1'b0;
            if (i_chip_center && chip_cnt < 3'(mil1553_pkg::SYNC_CHIPS)) begin
                chip_cnt <= chip_cnt + 1'b1;
                if (chip_cnt == 3'(mil1553_pkg::SYNC_CHIPS - 1)) begin  // Sixth chip
                    o_sync_done <= match_cmd | match_data;
                    o_sync_bad  <= ~(match_cmd | match_data);
                    o_is_data   <= match_data;
                end
            end
        end
    end

    // Chip shift register
    always_ff @(posedge i_clk) begin
        if (i_en && i_chip_center) begin
            chips <= pattern;
        end
    end

    a_chip_cnt : assert property (@(posedge i_clk) disable iff (i_reset)
        chip_cnt <= 3'(mil1553_pkg::SYNC_CHIPS))
        else $error("sync_detector chip count overrun: %0d", chip_cnt);

endmodule

`default_nettype wire

/* word_decoder/symbol_decoder.sv */
// MIL-STD-1553 symbol decoder
// Pairs 34 centre-sampled chips into 16 data bits and a parity bit,
// rejects equal chip pairs and checks odd parity

`default_nettype none

module symbol_decoder (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_en,           // Held high for the data field
    input  logic                           i_line,
    input  logic                           i_chip_center,
    output logic                           o_word_done,    // Pulse after the parity bit
    output logic                           o_parity_ok,    // Odd parity held
    output logic                           o_symbol_bad,   // Pulse, illegal Manchester pair
    output logic [mil1553_pkg::WORD_W-1:0] o_word          // MSB received first
);

    logic [5:0] chip_cnt;    // Chips taken so far
    logic       first_chip;  // First half of current bit
    logic       second;      // Current strobe closes a pair
    logic       pair_bad;
    logic       last_pair;
    logic       parity_acc;  // XOR of data bits so far

    assign second    = chip_cnt[0];
    assign pair_bad  = second & (i_line == first_chip);
    assign last_pair = (chip_cnt == 6'(mil1553_pkg::DATA_CHIPS - 1));

    // ------------------------------------------------------------
    // Control, counters cleared while disabled
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset || !i_en) begin
            chip_cnt     <= '0;
            parity_acc   <= 1'b0;
            o_word_done  <= 1'b0;
            o_symbol_bad <= 1'b0;
        end else begin
            o_word_done  <= 1'b0;
            o_symbol_bad <= 1'b0;
            if (i_chip_center && chip_cnt < 6'(mil1553_pkg::DATA_CHIPS)) begin
                chip_cnt <= chip_cnt + 1'b1;
                if (pair_bad) begin
                    o_symbol_bad <= 1'b1;
                end else if (second && last_pair) begin
                    o_word_done <= 1'b1;
                end else if (second) begin
                    parity_acc <= parity_acc ^ first_chip;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_en && i_chip_center) begin
            if (!second) begin
                first_chip <= i_line;  // Bit value is the first chip
            end else if (last_pair) begin
                o_parity_ok <= parity_acc ^ first_chip;  // 17 bits must XOR to one
            end else begin
                o_word <= {o_word[mil1553_pkg::WORD_W-2:0], first_chip};
            end
        end
    end

    a_done_xor_bad : assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_word_done && o_symbol_bad))
        else $error("symbol_decoder word done and symbol error together");

endmodule

`default_nettype wire

/* hdl/rx_control.sv */
// MIL-STD-1553 receive control
// Steps through sync, data and intermission, holds the word for the host
// and latches failure causes until cleared

`default_nettype none

module rx_control (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_bus_start,
    input  logic                           i_edge_bad,
    input  logic                           i_timeout,
    input  logic                           i_quiet,
    input  logic                           i_sync_done,
    input  logic                           i_is_data,
    input  logic                           i_sync_bad,
    input  logic                           i_word_done,
    input  logic                           i_parity_ok,
    input  logic                           i_symbol_bad,
    input  logic                           i_word_ready,  // Host takes the word
    input  logic                           i_fail_clear,  // Host acknowledges failure
    input  logic [mil1553_pkg::WORD_W-1:0] i_word,
    output logic                           o_sync_en,
    output logic                           o_data_en,
    output logic                           o_word_valid,
    output logic                           o_word_is_data,
    output logic                           o_fail,
    output logic                           o_fail_sync,
    output logic                           o_fail_manchester,
    output logic                           o_fail_parity,
    output logic                           o_fail_timing,
    output logic                           o_fail_timeout,
    output logic [mil1553_pkg::WORD_W-1:0] o_word
);

    enum logic [2:0] {IDLE, SYNC, DATA, GAP, DONE, FAIL} state, state_nxt;

    logic in_rx;
    logic cause_sync;
    logic cause_manchester;
    logic cause_parity;
    logic cause_timing;
    logic cause_timeout;
    logic any_cause;
    logic type_q;  // Sync type until the word completes

    // ------------------------------------------------------------
    // Failure causes, only while a word is coming in
    // ------------------------------------------------------------
    assign in_rx            = (state == SYNC) || (state == DATA);
    assign cause_sync       = (state == SYNC) & i_sync_bad;
    assign cause_manchester = (state == DATA) & i_symbol_bad;
    assign cause_parity     = (state == DATA) & i_word_done & ~i_parity_ok;
    assign cause_timing     = in_rx & i_edge_bad;
    assign cause_timeout    = in_rx & i_timeout;
    assign any_cause        = cause_sync | cause_manchester | cause_parity |
                              cause_timing | cause_timeout;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_bus_start) state_nxt = SYNC;
            SYNC:    if (any_cause) state_nxt = FAIL;
                     else if (i_sync_done) state_nxt = DATA;
            DATA:    if (any_cause) state_nxt = FAIL;
                     else if (i_word_done) state_nxt = GAP;
            GAP:     if (i_quiet) state_nxt = DONE;       // Bus must rest first
            DONE:    if (i_word_ready) state_nxt = IDLE;  // Bus ignored meanwhile
            FAIL:    if (i_fail_clear) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Flags are zero outside FAIL, so every cause of one cycle is kept
    always_ff @(posedge i_clk) begin
        if (i_reset || (state == FAIL && i_fail_clear)) begin
            o_fail_sync       <= 1'b0;
            o_fail_manchester <= 1'b0;
            o_fail_parity     <= 1'b0;
            o_fail_timing     <= 1'b0;
            o_fail_timeout    <= 1'b0;
        end else if (in_rx) begin
            o_fail_sync       <= cause_sync;
            o_fail_manchester <= cause_manchester;
            o_fail_parity     <= cause_parity;
            o_fail_timing     <= cause_timing;
            o_fail_timeout    <= cause_timeout;
        end
    end

    // Output word, loaded on the way into GAP
    always_ff @(posedge i_clk) begin
        if (state == SYNC && i_sync_done) begin
            type_q <= i_is_data;
        end
        if (state == DATA && state_nxt == GAP) begin
            o_word         <= i_word;
            o_word_is_data <= type_q;
        end
    end

    assign o_sync_en    = (state == SYNC);
    assign o_data_en    = (state == DATA);
    assign o_word_valid = (state == DONE);
    assign o_fail       = (state == FAIL);

    a_valid_not_fail : assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_word_valid && o_fail))
        else $error("rx_control word valid during failure");

endmodule

`default_nettype wire

/* hdl/mil1553_rx.sv */
// MIL-STD-1553 word receiver top level
// Line front end, sync and symbol decoders and receive control

`default_nettype none

module mil1553_rx (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_rx_pos,           // Transceiver rails
    input  logic                           i_rx_neg,
    input  logic                           i_word_ready,
    input  logic                           i_fail_clear,
    output logic                           o_word_valid,
    output logic [mil1553_pkg::WORD_W-1:0] o_word,
    output logic                           o_word_is_data,
    output logic                           o_fail,
    output logic                           o_fail_sync,
    output logic                           o_fail_manchester,
    output logic                           o_fail_parity,
    output logic                           o_fail_timing,
    output logic                           o_fail_timeout
);

    logic line;
    logic bus_start;
    logic chip_center;
    logic edge_bad;
    logic timeout;
    logic quiet;
    logic sync_en;
    logic data_en;
    logic sync_done;
    logic is_data;
    logic sync_bad;
    logic word_done;
    logic parity_ok;
    logic symbol_bad;
    logic [mil1553_pkg::WORD_W-1:0] word;

    // ------------------------------------------------------------
    // Line side
    // ------------------------------------------------------------
    rx_line_front u_front (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx_pos(i_rx_pos), .i_rx_neg(i_rx_neg),
        .o_line(line), .o_bus_start(bus_start), .o_edge(),
        .o_chip_center(chip_center), .o_edge_bad(edge_bad), .o_timeout(timeout),
        .o_quiet(quiet)
    );

    sync_detector u_sync (
        .i_clk(i_clk), .i_reset(i_reset), .i_en(sync_en), .i_line(line),
        .i_chip_center(chip_center), .o_sync_done(sync_done), .o_is_data(is_data),
        .o_sync_bad(sync_bad)
    );

    symbol_decoder u_symbol (
        .i_clk(i_clk), .i_reset(i_reset), .i_en(data_en), .i_line(line),
        .i_chip_center(chip_center), .o_word_done(word_done), .o_parity_ok(parity_ok),
        .o_symbol_bad(symbol_bad), .o_word(word)
    );

    // ------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------
    rx_control u_ctrl (
        .i_clk(i_clk), .i_reset(i_reset), .i_bus_start(bus_start),
        .i_edge_bad(edge_bad), .i_timeout(timeout), .i_quiet(quiet),
        .i_sync_done(sync_done), .i_is_data(is_data), .i_sync_bad(sync_bad),
        .i_word_done(word_done), .i_parity_ok(parity_ok), .i_symbol_bad(symbol_bad),
        .i_word_ready(i_word_ready), .i_fail_clear(i_fail_clear), .i_word(word),
        .o_sync_en(sync_en), .o_data_en(data_en), .o_word_valid(o_word_valid),
        .o_word_is_data(o_word_is_data), .o_fail(o_fail), .o_fail_sync(o_fail_sync),
        .o_fail_manchester(o_fail_manchester), .o_fail_parity(o_fail_parity),
        .o_fail_timing(o_fail_timing), .o_fail_timeout(o_fail_timeout), .o_word(o_word)
    );

endmodule

`default_nettype wire

/* testbench/tb_bus_driver.svh */
// MIL-STD-1553 bus driver tasks
// Drive Manchester chips, sync fields and whole words onto both rails

`ifndef TB_BUS_DRIVER_SVH
`define TB_BUS_DRIVER_SVH

int prev_jit;  // Offset of the last chip boundary from nominal

// One chip, boundary jitter does not accumulate over long runs
task automatic drive_chip(input bit level, input int jit_max, input int extra);
    int jit;
    int len;
    jit = 0;
    if (jit_max > 0) begin
        jit = int'($urandom_range(2 * jit_max)) - jit_max;
    end
    len      = CHIP + jit - prev_jit + extra;
    prev_jit = jit;
    rx_pos   = level;   // High chip on pos rail
    rx_neg   = ~level;  // Low chip on neg rail
    repeat (len) @(negedge clk);
endtask

// Both rails low
task automatic drive_idle(input int cycles);
    rx_pos   = 1'b0;
    rx_neg   = 1'b0;
    prev_jit = 0;
    repeat (cycles) @(negedge clk);
endtask

task automatic drive_sync(input logic [5:0] pattern, input int jit_max);
    for (int i = 5; i >= 0; i--) begin
        drive_chip(pattern[i], jit_max, 0);  // Oldest chip first
    end
endtask

// Bit value is the first chip, extra stretches the second one
task automatic drive_bit(input bit value, input int jit_max, input int extra);
    drive_chip(value, jit_max, 0);
    drive_chip(~value, jit_max, extra);
endtask

task automatic drive_word(input bit is_data, input logic [15:0] data, input bit par,
                          input int jit_max);
    drive_sync(is_data ? mil1553_pkg::SYNC_DATA : mil1553_pkg::SYNC_CMD, jit_max);
    for (int i = mil1553_pkg::WORD_W - 1; i >= 0; i--) begin
        drive_bit(data[i], jit_max, 0);  // MSB first
    end
    drive_bit(par, jit_max, 0);
endtask

// Parity bit that makes the count of ones odd
function automatic bit odd_parity(input logic [15:0] data);
    return ~^data;
endfunction

`endif

/* testbench/tb_mil1553_rx.sv */
// MIL-STD-1553 receiver testbench
// Random words, back-pressure and each failure cause, checked by assertions

`default_nettype none

module tb_mil1553_rx;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CHIP       = int'(mil1553_pkg::CYCLES_PER_CHIP);
    localparam int HALF       = int'(mil1553_pkg::CYCLES_HALF_CHIP);
    localparam int GAP        = int'(mil1553_pkg::CYCLES_GAP);
    localparam int TMO        = int'(mil1553_pkg::CYCLES_TIMEOUT);
    localparam int JIT_MAX    = int'(mil1553_pkg::CYCLES_TOL) * 2 / 5;  // 10 cycles
    localparam int WAIT_LIMIT = 4 * 20 * 2 * CHIP;
    localparam logic [4:0] FLAG_SYNC = 5'b10000;  // Order of fail_flags
    localparam logic [4:0] FLAG_MAN  = 5'b01000;
    localparam logic [4:0] FLAG_PAR  = 5'b00100;
    localparam logic [4:0] FLAG_TIM  = 5'b00010;
    localparam logic [4:0] FLAG_TMO  = 5'b00001;

    logic clk = 1'b0;
    logic reset, rx_pos, rx_neg, word_ready, fail_clear;
    logic word_valid, word_is_data, fail;
    logic f_sync, f_man, f_par, f_tim, f_tmo;
    logic [15:0] word;
    logic [4:0]  fail_flags;
    logic [21:0] expect_q[$];  // {flags, is_data, word}
    logic [15:0] exp_word;
    logic        exp_is_data;
    logic [4:0]  exp_flags;
    logic        bus_seen;

    always #2 clk = ~clk;
    assign fail_flags = {f_sync, f_man, f_par, f_tim, f_tmo};

    mil1553_rx i_dut (
        .i_clk(clk), .i_reset(reset), .i_rx_pos(rx_pos), .i_rx_neg(rx_neg),
        .i_word_ready(word_ready), .i_fail_clear(fail_clear), .o_word_valid(word_valid),
        .o_word(word), .o_word_is_data(word_is_data), .o_fail(fail),
        .o_fail_sync(f_sync), .o_fail_manchester(f_man), .o_fail_parity(f_par),
        .o_fail_timing(f_tim), .o_fail_timeout(f_tmo)
    );

    `include "tb_bus_driver.svh"

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        stop_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // ------------------------------------------------------------
    // Checks against the scoreboard entry of the current word
    // ------------------------------------------------------------
    a_reset_quiet : assert property (@(posedge clk) disable iff (reset)
        !bus_seen |-> !word_valid && !fail && fail_flags == '0)
        else value_error("o_fail_flags", $sampled({word_valid, fail, fail_flags}), 0);
    a_valid_wanted : assert property (@(posedge clk) disable iff (reset)
        $rose(word_valid) |-> exp_flags == '0)
        else value_error("o_word_valid", 1, 0);
    a_word : assert property (@(posedge clk) disable iff (reset)
        $rose(word_valid) |-> word == exp_word)
        else value_error("o_word", $sampled(word), exp_word);
    a_word_type : assert property (@(posedge clk) disable iff (reset)
        $rose(word_valid) |-> word_is_data == exp_is_data)
        else value_error("o_word_is_data", $sampled(word_is_data), exp_is_data);
    a_hold : assert property (@(posedge clk) disable iff (reset)
        word_valid && !word_ready |=> word_valid && $stable(word) && $stable(word_is_data))
        else value_error("o_word_valid o_word", $sampled({word_valid, word}), exp_word);
    a_release : assert property (@(posedge clk) disable iff (reset)
        word_valid && word_ready |=> !word_valid)
        else value_error("o_word_valid", 1, 0);
    a_fail_cause : assert property (@(posedge clk) disable iff (reset)
        $rose(fail) |-> fail_flags == exp_flags)
        else value_error("o_fail_flags", $sampled(fail_flags), exp_flags);
    a_fail_hold : assert property (@(posedge clk) disable iff (reset)
        fail && !fail_clear |=> fail && $stable(fail_flags))
        else value_error("o_fail o_fail_flags", $sampled({fail, fail_flags}), exp_flags);
    a_fail_clear : assert property (@(posedge clk) disable iff (reset)
        fail && fail_clear |=> !fail && fail_flags == '0)
        else value_error("o_fail o_fail_flags", $sampled({fail, fail_flags}), 0);
    a_flag_needs_fail : assert property (@(posedge clk) disable iff (reset)
        fail_flags != '0 |-> fail)
        else value_error("o_fail", 0, 1);

    // DUT stalls the bus per word, so one entry is live at a time
    task automatic arm_expected(input logic [15:0] w, input bit d, input logic [4:0] f);
        logic [21:0] entry;
        expect_q.push_back({f, d, w});
        entry       = expect_q.pop_front();
        exp_word    = entry[15:0];
        exp_is_data = entry[16];
        exp_flags   = entry[21:17];
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!word_valid && !fail && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) stop_run("Timeout while waiting for a word or a failure");
    endtask

    task automatic pulse_and_wait(input bit is_ready);
        int n;
        n = 0;
        if (is_ready) word_ready = 1'b1;
        else fail_clear = 1'b1;
        @(negedge clk);
        word_ready = 1'b0;
        fail_clear = 1'b0;
        while ((word_valid || fail) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) stop_run("Timeout while waiting for the receiver to go idle");
    endtask

    task automatic run_good(input bit is_data, input int hold);
        logic [15:0] w;
        w = 16'($urandom);
        arm_expected(w, is_data, '0);
        drive_word(is_data, w, odd_parity(w), JIT_MAX);
        drive_idle(GAP + 50);
        wait_result();
        repeat (hold) @(negedge clk);  // Back-pressure
        pulse_and_wait(1'b1);
    endtask

    task automatic finish_fault();
        drive_idle(GAP + 50);
        wait_result();
        pulse_and_wait(1'b0);
        run_good(1'b0, 0);  // Receiver recovers
    endtask

    initial begin
        logic [15:0] w;
        {rx_pos, rx_neg, word_ready, fail_clear} = '0;
        reset    = 1'b1;
        bus_seen = 1'b0;
        prev_jit = 0;
        arm_expected('0, 1'b0, '0);
        void'($urandom(39073));
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (20) @(negedge clk);
        bus_seen = 1'b1;

        for (int i = 0; i < 8; i++) begin
            run_good(i[0], int'($urandom_range(2000)));
        end

        w = 16'($urandom);
        arm_expected(w, 1'b0, FLAG_PAR);
        drive_word(1'b0, w, ~odd_parity(w), 0);
        finish_fault();

        // Equal high pair between a 1 and a 0 bit
        arm_expected('0, 1'b0, FLAG_MAN);
        drive_sync(mil1553_pkg::SYNC_CMD, 0);
        drive_bit(1'b1, 0, 0);
        drive_chip(1'b1, 0, 0);
        drive_chip(1'b1, 0, 0);
        for (int i = 0; i < 16; i++) drive_bit(1'b0, 0, 0);
        finish_fault();

        arm_expected('0, 1'b0, FLAG_SYNC);
        drive_sync(6'b101010, 0);
        for (int i = 0; i < 17; i++) drive_bit(1'b0, 0, 0);
        finish_fault();

        arm_expected('0, 1'b0, FLAG_TIM);
        drive_sync(mil1553_pkg::SYNC_CMD, 0);
        drive_bit(1'b1, 0, 0);
        drive_bit(1'b1, 0, HALF);  // Late edge after the low chip
        for (int i = 0; i < 15; i++) drive_bit(1'b0, 0, 0);
        finish_fault();

        arm_expected('0, 1'b1, FLAG_TMO);
        drive_sync(mil1553_pkg::SYNC_DATA, 0);
        drive_chip(1'b1, 0, TMO + CHIP);  // Rails stuck after sync
        finish_fault();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
common/mil1553_pkg.sv
hdl/rx_line_front.sv
word_decoder/sync_detector.sv
word_decoder/symbol_decoder.sv
hdl/rx_control.sv
hdl/mil1553_rx.sv
testbench/tb_mil1553_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MIL-STD-1553 receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    --top-module tb_mil1553_rx -f compile.f -o Vtb_mil1553_rx > sim.log 2>&1 \
    && ./obj_dir/Vtb_mil1553_rx >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0
